/* verilog.f */
+incdir+common
common/sysregPkg.sv
sensor/sensorFifo.sv
sensor/motorFeedbackChannel.sv
source/avalonRegBank.sv
source/sysregTop.sv
dv/sysreg_assertions.sv
dv/sysregTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= sysregTb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= All checks passed
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/sysregTb.sv */
// testbench of the system register block
// clock, reset, bus and sample stimulus
// queue model per fifo, per-test result lines, cycle limit
`include "sysreg_settings.svh"

module sysregTb;

    // tests need well under 1500 cycles
    localparam int cycleLimit = 4000;
    localparam int slotEnc    = 0;
    localparam int slotSpeed  = 1;
    localparam int slotVolt   = 2;
    localparam int slotAmpe   = 3;

    logic                       clk;
    logic                       reset_n;
    logic [`ADDR_WIDTH-1:0]     address;
    logic                       read;
    logic                       write;
    logic [`BUS_WIDTH-1:0]      writeData;
    logic [`BUS_WIDTH-1:0]      readData;
    logic [`SPEED_WIDTH:0]      motorSpeed [`NUM_MOTORS];
    logic [`SENSOR_WIDTH-1:0]   motorSensor [`NUM_MOTORS];
    logic [`BUS_WIDTH-1:0]      motorEncoder [`NUM_MOTORS];
    logic [`BUS_WIDTH-1:0]      fbDirection;
    logic [`BUS_WIDTH-1:0]      pwmDuty;
    logic [`BUS_WIDTH-1:0]      motorDir;
    logic [`BUS_WIDTH-1:0]      motorCtrl;

    // ====================
    // fifo model
    // ====================
    logic [`SPEED_WIDTH-1:0]    speedQ [`NUM_MOTORS][$];
    logic [`SAMPLE_WIDTH-1:0]   voltQ [`NUM_MOTORS][$];
    logic [`SAMPLE_WIDTH-1:0]   ampeQ [`NUM_MOTORS][$];

    int errors = 0;
    int testStart = 0;
    int testsPassed = 0;
    int testsFailed = 0;
    int cycles = 0;
    int reservedAddr [11] = '{5, 6, 11, 16, 21, 26, 27, 28, 29, 30, 31};

    sysregTop i_sysregTop (.*);

    bind sysregTop sysregAssertions i_checker (
        .clk       (clk),
        .reset_n   (reset_n),
        .address   (address),
        .read      (read),
        .write     (write),
        .readData  (readData),
        .pwmDuty   (pwmDuty),
        .motorDir  (motorDir),
        .motorCtrl (motorCtrl)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [`ADDR_WIDTH-1:0] blockAddr(input int m, input int slot);
        return `ADDR_WIDTH'(`MOTOR_REG_BASE + `MOTOR_REG_STRIDE * m + slot);
    endfunction

    // status bits from model occupancy
    function automatic logic [`BUS_WIDTH-1:0] expectedStatus();
        logic [`BUS_WIDTH-1:0] s;
        s = '0;
        for (int m = 0; m < `NUM_MOTORS; m++) begin
            s[m]         = speedQ[m].size() != 0;
            s[8 + 2*m]   = voltQ[m].size() != 0;
            s[9 + 2*m]   = ampeQ[m].size() != 0;
        end
        return s;
    endfunction

    task automatic checkWord(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %s expected %h got %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic busWrite(input logic [`ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        address   <= addr;
        write     <= 1'b1;
        writeData <= data;
        @(posedge clk);
        write     <= 1'b0;
        @(negedge clk);
    endtask

    // bank samples read one edge later, data valid after that edge
    task automatic checkRead(input logic [`ADDR_WIDTH-1:0] addr, input logic [31:0] expected);
        @(posedge clk);
        address <= addr;
        read    <= 1'b1;
        @(posedge clk);
        read    <= 1'b0;
        @(negedge clk);
        checkWord($sformatf("readData @%0d", addr), expected, readData);
    endtask

    task automatic readSample(input int m, input int slot);
        logic [`SAMPLE_WIDTH-1:0] sample;
        logic [31:0] expected;
        if (slot == slotSpeed) begin
            expected = {1'b0, speedQ[m].pop_front()};
        end else begin
            sample   = (slot == slotVolt) ? voltQ[m].pop_front() : ampeQ[m].pop_front();
            expected = 32'(sample[`ADC_WIDTH-1:0]);
        end
        checkRead(blockAddr(m, slot), expected);
    endtask

    // one-cycle valid, full fifo drops the sample
    task automatic pushSpeed(input int m);
        logic [`SPEED_WIDTH-1:0] data;
        data = `SPEED_WIDTH'($urandom());
        @(posedge clk);
        motorSpeed[m] <= {1'b1, data};
        @(posedge clk);
        motorSpeed[m] <= '0;
        if (speedQ[m].size() < `FIFO_DEPTH) speedQ[m].push_back(data);
    endtask

    task automatic pushSensor(input int m, input logic vValid, input logic aValid);
        logic [`SAMPLE_WIDTH-1:0] v;
        logic [`SAMPLE_WIDTH-1:0] a;
        v = `SAMPLE_WIDTH'($urandom());
        a = `SAMPLE_WIDTH'($urandom());
        @(posedge clk);
        motorSensor[m] <= {vValid, aValid, v, a};
        @(posedge clk);
        motorSensor[m] <= '0;
        if (vValid && voltQ[m].size() < `FIFO_DEPTH) voltQ[m].push_back(v);
        if (aValid && ampeQ[m].size() < `FIFO_DEPTH) ampeQ[m].push_back(a);
    endtask

    task automatic drainAll();
        for (int m = 0; m < `NUM_MOTORS; m++) begin
            while (speedQ[m].size() > 0) readSample(m, slotSpeed);
            while (voltQ[m].size() > 0) readSample(m, slotVolt);
            while (ampeQ[m].size() > 0) readSample(m, slotAmpe);
        end
    endtask

    task automatic endTest(input string name);
        if (errors == testStart) begin
            testsPassed++;
            $display("test %s: pass", name);
        end else begin
            testsFailed++;
            $display("test %s: FAIL with %0d errors", name, errors - testStart);
        end
        testStart = errors;
    endtask

    // ====================
    // test sequence
    // ====================
    initial begin
        logic [31:0] pwmExp;
        logic [31:0] dirExp;
        logic [31:0] ctrlExp;
        void'($urandom(97));
        reset_n     = 1'b0;
        address     = '0;
        read        = 1'b0;
        write       = 1'b0;
        writeData   = '0;
        fbDirection = '0;
        for (int m = 0; m < `NUM_MOTORS; m++) begin
            motorSpeed[m]   = '0;
            motorSensor[m]  = '0;
            motorEncoder[m] = '0;
        end
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;

        // reset values and reserved words
        checkRead(`REG_PWM_DUTY, 0);
        checkRead(`REG_MOTOR_DIR, 0);
        checkRead(`REG_MOTOR_CTRL, 0);
        checkRead(`REG_FIFO_STATUS, expectedStatus());
        checkWord("pwmDuty", 0, pwmDuty);
        checkWord("motorDir", 0, motorDir);
        checkWord("motorCtrl", 0, motorCtrl);
        foreach (reservedAddr[i]) checkRead(`ADDR_WIDTH'(reservedAddr[i]), `RESERVED_WORD);
        endTest("reset values");

        // control registers, clear bit kept low
        pwmExp  = $urandom();
        dirExp  = $urandom();
        ctrlExp = $urandom() & ~(32'h1 << `CLEAR_ALL_BIT);
        busWrite(`REG_PWM_DUTY, pwmExp);
        busWrite(`REG_MOTOR_DIR, dirExp);
        busWrite(`REG_MOTOR_CTRL, ctrlExp);
        checkRead(`REG_PWM_DUTY, pwmExp);
        checkRead(`REG_MOTOR_DIR, dirExp);
        checkRead(`REG_MOTOR_CTRL, ctrlExp);
        busWrite(`REG_FB_DIR, $urandom());
        busWrite(`REG_FIFO_STATUS, $urandom());
        checkRead(`REG_FB_DIR, fbDirection);
        checkRead(`REG_FIFO_STATUS, expectedStatus());
        checkWord("pwmDuty", pwmExp, pwmDuty);
        checkWord("motorDir", dirExp, motorDir);
        checkWord("motorCtrl", ctrlExp, motorCtrl);
        endTest("register writes");

        // pass-through inputs
        @(posedge clk);
        fbDirection <= $urandom();
        foreach (motorEncoder[m]) motorEncoder[m] <= $urandom();
        @(negedge clk);
        checkRead(`REG_FB_DIR, fbDirection);
        for (int m = 0; m < `NUM_MOTORS; m++) checkRead(blockAddr(m, slotEnc), motorEncoder[m]);
        endTest("read-only inputs");

        // motor 2 gets one sample too many
        for (int m = 0; m < `NUM_MOTORS; m++) begin
            repeat ((m == 2) ? 17 : 3) pushSpeed(m);
        end
        checkRead(`REG_FIFO_STATUS, expectedStatus());
        drainAll();
        checkRead(`REG_FIFO_STATUS, expectedStatus());
        endTest("speed fifos");

        // mixed valid bits per motor
        pushSensor(0, 1'b1, 1'b1);
        pushSensor(1, 1'b1, 1'b0);
        pushSensor(1, 1'b1, 1'b1);
        pushSensor(2, 1'b0, 1'b1);
        pushSensor(3, 1'b1, 1'b1);
        pushSensor(3, 1'b0, 1'b1);
        checkRead(`REG_FIFO_STATUS, expectedStatus());
        // motor 1 voltage pop leaves motor 0 alone
        readSample(1, slotVolt);
        checkRead(`REG_FIFO_STATUS, expectedStatus());
        drainAll();
        checkRead(`REG_FIFO_STATUS, expectedStatus());
        endTest("sensor fifos");

        // flush everything, then refill
        for (int m = 0; m < `NUM_MOTORS; m++) begin
            pushSpeed(m);
            pushSensor(m, 1'b1, 1'b1);
        end
        checkRead(`REG_FIFO_STATUS, expectedStatus());
        busWrite(`REG_MOTOR_CTRL, 32'h1 << `CLEAR_ALL_BIT);
        busWrite(`REG_MOTOR_CTRL, 0);
        for (int m = 0; m < `NUM_MOTORS; m++) begin
            speedQ[m].delete();
            voltQ[m].delete();
            ampeQ[m].delete();
        end
        checkRead(`REG_FIFO_STATUS, 0);
        pushSpeed(1);
        pushSensor(3, 1'b1, 1'b1);
        checkRead(`REG_FIFO_STATUS, expectedStatus());
        drainAll();
        checkWord("motorCtrl", 0, motorCtrl);
        endTest("clear all");

        $display("tests passed %0d, tests failed %0d, check errors %0d, assertion errors %0d",
                 testsPassed, testsFailed, errors, i_sysregTop.i_checker.failCount);
        if (errors == 0 && i_sysregTop.i_checker.failCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* dv/sysreg_assertions.sv */
// bus and status word rules of the register block
// bound into the top level, counts its own failures
`include "sysreg_settings.svh"

module sysregAssertions (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic [`ADDR_WIDTH-1:0]  address,
    input  logic                    read,
    input  logic                    write,
    input  logic [`BUS_WIDTH-1:0]   readData,
    input  logic [`BUS_WIDTH-1:0]   pwmDuty,
    input  logic [`BUS_WIDTH-1:0]   motorDir,
    input  logic [`BUS_WIDTH-1:0]   motorCtrl
);

    int failCount = 0;

    // unmapped word or spare slot of a motor block
    function automatic logic isReserved(input logic [`ADDR_WIDTH-1:0] addr);
        int offset;
        offset = int'(addr) - `MOTOR_REG_BASE;
        if (int'(addr) <= `REG_FIFO_STATUS) return 1'b0;
        if (offset < 0 || offset >= `NUM_MOTORS * `MOTOR_REG_STRIDE) return 1'b1;
        return (offset % `MOTOR_REG_STRIDE) == `MOTOR_REG_STRIDE - 1;
    endfunction

    // reserved words return the fixed pattern
    assert property (@(posedge clk) disable iff (!reset_n)
        read && isReserved(address) |=> readData == `RESERVED_WORD)
    else begin
        failCount++;
        $error("reserved address did not read back the reserved pattern");
    end

    // control outputs hold without a write
    assert property (@(posedge clk) disable iff (!reset_n)
        !write |=> $stable(pwmDuty) && $stable(motorDir) && $stable(motorCtrl))
    else begin
        failCount++;
        $error("control output changed in a cycle without a write");
    end

    // unused status bits
    assert property (@(posedge clk) disable iff (!reset_n)
        read && address == `REG_FIFO_STATUS |=> readData[7:4] == '0 && readData[31:16] == '0)
    else begin
        failCount++;
        $error("status word has an unused bit set");
    end

endmodule

/* source/sysregTop.sv */
// top level of the system register block
// register bank plus one feedback channel per motor
`include "sysreg_settings.svh"

module sysregTop (
    input  logic                        clk,
    input  logic                        reset_n,
    // bus slave
    input  logic [`ADDR_WIDTH-1:0]      address,
    input  logic                        read,
    input  logic                        write,
    input  logic [`BUS_WIDTH-1:0]       writeData,
    output logic [`BUS_WIDTH-1:0]       readData,
    // motor side
    input  logic [`SPEED_WIDTH:0]       motorSpeed [`NUM_MOTORS],
    input  logic [`SENSOR_WIDTH-1:0]    motorSensor [`NUM_MOTORS],
    input  logic [`BUS_WIDTH-1:0]       motorEncoder [`NUM_MOTORS],
    input  logic [`BUS_WIDTH-1:0]       fbDirection,
    output logic [`BUS_WIDTH-1:0]       pwmDuty,
    output logic [`BUS_WIDTH-1:0]       motorDir,
    output logic [`BUS_WIDTH-1:0]       motorCtrl
);

    import sysregPkg::*;

    // ====================
    // bank to channel wires
    // ====================
    logic                       fifoClear;
    logic [`NUM_MOTORS-1:0]     speedPop;
    logic [`NUM_MOTORS-1:0]     voltPop;
    logic [`NUM_MOTORS-1:0]     ampePop;
    logic [`SPEED_WIDTH-1:0]    speedHead [`NUM_MOTORS];
    adcSampleT                  voltHead [`NUM_MOTORS];
    adcSampleT                  ampeHead [`NUM_MOTORS];
    logic [`NUM_MOTORS-1:0]     speedNotEmpty;
    logic [`NUM_MOTORS-1:0]     voltNotEmpty;
    logic [`NUM_MOTORS-1:0]     ampeNotEmpty;

    avalonRegBank i_regBank (
        .clk           (clk),
        .reset_n       (reset_n),
        .address       (address),
        .read          (read),
        .write         (write),
        .writeData     (writeData),
        .fbDirection   (fbDirection),
        .motorEncoder  (motorEncoder),
        .speedHead     (speedHead),
        .voltHead      (voltHead),
        .ampeHead      (ampeHead),
        .speedNotEmpty (speedNotEmpty),
        .voltNotEmpty  (voltNotEmpty),
        .ampeNotEmpty  (ampeNotEmpty),
        .readData      (readData),
        .pwmDuty       (pwmDuty),
        .motorDir      (motorDir),
        .motorCtrl     (motorCtrl),
        .fifoClear     (fifoClear),
        .speedPop      (speedPop),
        .voltPop       (voltPop),
        .ampePop       (ampePop)
    );

    // one channel per motor, shared clear
    for (genvar m = 0; m < `NUM_MOTORS; m++) begin : gMotor
        motorFeedbackChannel i_channel (
            .clk           (clk),
            .reset_n       (reset_n),
            .fifoClear     (fifoClear),
            .speedPop      (speedPop[m]),
            .voltPop       (voltPop[m]),
            .ampePop       (ampePop[m]),
            .speedIn       (motorSpeed[m]),
            .sensorIn      (motorSensor[m]),
            .speedHead     (speedHead[m]),
            .voltHead      (voltHead[m]),
            .ampeHead      (ampeHead[m]),
            .speedNotEmpty (speedNotEmpty[m]),
            .voltNotEmpty  (voltNotEmpty[m]),
            .ampeNotEmpty  (ampeNotEmpty[m])
        );
    end

endmodule

/* source/avalonRegBank.sv */
// memory mapped register bank of the motor controller
// control registers, read mux and fifo status word
// one-cycle pop strobes toward the feedback fifos
`include "sysreg_settings.svh"

module avalonRegBank (
    input  logic                        clk,
    input  logic                        reset_n,
    // bus slave side
    input  logic [`ADDR_WIDTH-1:0]      address,
    input  logic                        read,
    input  logic                        write,
    input  logic [`BUS_WIDTH-1:0]       writeData,
    // read-only pass-through values
    input  logic [`BUS_WIDTH-1:0]       fbDirection,
    input  logic [`BUS_WIDTH-1:0]       motorEncoder [`NUM_MOTORS],
    // fifo heads per motor
    input  logic [`SPEED_WIDTH-1:0]     speedHead [`NUM_MOTORS],
    input  sysregPkg::adcSampleT        voltHead [`NUM_MOTORS],
    input  sysregPkg::adcSampleT        ampeHead [`NUM_MOTORS],
    input  logic [`NUM_MOTORS-1:0]      speedNotEmpty,
    input  logic [`NUM_MOTORS-1:0]      voltNotEmpty,
    input  logic [`NUM_MOTORS-1:0]      ampeNotEmpty,
    // registered outputs
    output logic [`BUS_WIDTH-1:0]       readData,
    output logic [`BUS_WIDTH-1:0]       pwmDuty,
    output logic [`BUS_WIDTH-1:0]       motorDir,
    output logic [`BUS_WIDTH-1:0]       motorCtrl,
    output logic                        fifoClear,
    output logic [`NUM_MOTORS-1:0]      speedPop,
    output logic [`NUM_MOTORS-1:0]      voltPop,
    output logic [`NUM_MOTORS-1:0]      ampePop
);

    import sysregPkg::*;

    // word offsets inside a motor block
    localparam int slotEncoder = 0;
    localparam int slotSpeed   = 1;
    localparam int slotVolt    = 2;
    localparam int slotAmpe    = 3;

    // first status bit of the sensor flag pairs
    localparam int sensorFlagBase = 8;

    logic [`BUS_WIDTH-1:0]  statusWord;
    logic [`BUS_WIDTH-1:0]  selWord;
    logic [`NUM_MOTORS-1:0] selSpeedPop;
    logic [`NUM_MOTORS-1:0] selVoltPop;
    logic [`NUM_MOTORS-1:0] selAmpePop;

    // bus address of one word in a motor block
    function automatic logic [`ADDR_WIDTH-1:0] motorAddr(input int motor, input int slot);
        return `ADDR_WIDTH'(`MOTOR_REG_BASE + `MOTOR_REG_STRIDE * motor + slot);
    endfunction

    // converter result only, zero extended
    function automatic logic [`BUS_WIDTH-1:0] adcWord(input adcSampleT sample);
        return `BUS_WIDTH'(sample.fields.result);
    endfunction

    // clear bit comes straight off the control flop
    assign fifoClear = motorCtrl[`CLEAR_ALL_BIT];

    // ====================
    // fifo status word
    // ====================
    always_comb begin
        statusWord = '0;
        statusWord[`NUM_MOTORS-1:0] = speedNotEmpty;
        // voltage then current, one pair per motor
        for (int m = 0; m < `NUM_MOTORS; m++) begin
            statusWord[sensorFlagBase + 2*m]     = voltNotEmpty[m];
            statusWord[sensorFlagBase + 2*m + 1] = ampeNotEmpty[m];
        end
    end

    // ====================
    // read decode
    // ====================
    always_comb begin
        // anything unmapped reads the reserved pattern
        selWord     = `RESERVED_WORD;
        selSpeedPop = '0;
        selVoltPop  = '0;
        selAmpePop  = '0;

        case (address)
            `REG_PWM_DUTY:    selWord = pwmDuty;
            `REG_MOTOR_DIR:   selWord = motorDir;
            `REG_FB_DIR:      selWord = fbDirection;
            `REG_MOTOR_CTRL:  selWord = motorCtrl;
            `REG_FIFO_STATUS: selWord = statusWord;
            default:          selWord = `RESERVED_WORD;
        endcase

        // motor blocks, spare slot stays reserved
        for (int m = 0; m < `NUM_MOTORS; m++) begin
            if (address == motorAddr(m, slotEncoder)) begin
                selWord = motorEncoder[m];
            end
            if (address == motorAddr(m, slotSpeed)) begin
                // zero above the payload
                selWord        = `BUS_WIDTH'(speedHead[m]);
                selSpeedPop[m] = 1'b1;
            end
            if (address == motorAddr(m, slotVolt)) begin
                selWord       = adcWord(voltHead[m]);
                selVoltPop[m] = 1'b1;
            end
            if (address == motorAddr(m, slotAmpe)) begin
                selWord       = adcWord(ampeHead[m]);
                selAmpePop[m] = 1'b1;
            end
        end
    end

    // ====================
    // bus cycle
    // ====================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            readData  <= '0;
            pwmDuty   <= '0;
            motorDir  <= '0;
            motorCtrl <= '0;
            speedPop  <= '0;
            voltPop   <= '0;
            ampePop   <= '0;
        end else begin
            // strobes last one cycle only
            speedPop <= '0;
            voltPop  <= '0;
            ampePop  <= '0;

            if (read) begin
                // head seen now, pop lands next edge
                readData <= selWord;
                speedPop <= selSpeedPop;
                voltPop  <= selVoltPop;
                ampePop  <= selAmpePop;
            end else if (write) begin
                // read-only and reserved words ignore writes
                case (address)
                    `REG_PWM_DUTY:   pwmDuty   <= writeData;
                    `REG_MOTOR_DIR:  motorDir  <= writeData;
                    `REG_MOTOR_CTRL: motorCtrl <= writeData;
                    default:         motorCtrl <= motorCtrl;
                endcase
            end
        end
    end

endmodule

/* sensor/motorFeedbackChannel.sv */
// feedback fifos of one motor
// splits speed and sensor words into flags and payloads
// speed, voltage and current fifo instances
`include "sysreg_settings.svh"

module motorFeedbackChannel (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        fifoClear,
    // pop strobes from the register bank
    input  logic                        speedPop,
    input  logic                        voltPop,
    input  logic                        ampePop,
    // raw sample words
    input  logic [`SPEED_WIDTH:0]       speedIn,
    input  logic [`SENSOR_WIDTH-1:0]    sensorIn,
    // fifo heads
    output logic [`SPEED_WIDTH-1:0]     speedHead,
    output sysregPkg::adcSampleT        voltHead,
    output sysregPkg::adcSampleT        ampeHead,
    // not-empty flags for the status word
    output logic                        speedNotEmpty,
    output logic                        voltNotEmpty,
    output logic                        ampeNotEmpty
);

    import sysregPkg::*;

    logic                       speedValid;
    logic [`SPEED_WIDTH-1:0]    speedData;
    logic                       voltValid;
    logic                       ampeValid;
    adcSampleT                  voltIn;
    adcSampleT                  ampeIn;

    // ====================
    // word split
    // ====================

    // speed valid is the top bit
    assign speedValid = speedIn[`SPEED_WIDTH];
    assign speedData  = speedIn[`SPEED_WIDTH-1:0];

    // sensor word {voltValid, ampeValid, voltage, current}
    assign voltValid  = sensorIn[`SENSOR_WIDTH-1];
    assign ampeValid  = sensorIn[`SENSOR_WIDTH-2];
    assign voltIn     = sensorIn[2*`SAMPLE_WIDTH-1:`SAMPLE_WIDTH];
    assign ampeIn     = sensorIn[`SAMPLE_WIDTH-1:0];

    // ====================
    // sample fifos
    // ====================

    sensorFifo #(.dataWidth(`SPEED_WIDTH)) i_speedFifo (
        .clk      (clk),
        .reset_n  (reset_n),
        .clear    (fifoClear),
        .push     (speedValid),
        .pop      (speedPop),
        .pushData (speedData),
        .head     (speedHead),
        .notEmpty (speedNotEmpty)
    );

    // voltage samples stored raw
    sensorFifo #(.dataWidth(`SAMPLE_WIDTH)) i_voltFifo (
        .clk      (clk),
        .reset_n  (reset_n),
        .clear    (fifoClear),
        .push     (voltValid),
        .pop      (voltPop),
        .pushData (voltIn.raw),
        .head     (voltHead),
        .notEmpty (voltNotEmpty)
    );

    // current samples, same format
    sensorFifo #(.dataWidth(`SAMPLE_WIDTH)) i_ampeFifo (
        .clk      (clk),
        .reset_n  (reset_n),
        .clear    (fifoClear),
        .push     (ampeValid),
        .pop      (ampePop),
        .pushData (ampeIn.raw),
        .head     (ampeHead),
        .notEmpty (ampeNotEmpty)
    );

endmodule

/* sensor/sensorFifo.sv */
// single clock show-ahead sample fifo
// synchronous clear, drops pushes while full
`include "sysreg_settings.svh"

module sensorFifo #(
    parameter int dataWidth = 16
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    clear,
    input  logic                    push,
    input  logic                    pop,
    input  logic [dataWidth-1:0]    pushData,
    output logic [dataWidth-1:0]    head,
    output logic                    notEmpty
);

    localparam int ptrWidth = (`FIFO_DEPTH > 1) ? $clog2(`FIFO_DEPTH) : 1;
    localparam int cntWidth = $clog2(`FIFO_DEPTH + 1);
    localparam logic [ptrWidth-1:0] lastIdx = ptrWidth'(`FIFO_DEPTH - 1);

    logic [dataWidth-1:0]   mem [`FIFO_DEPTH];
    logic [ptrWidth-1:0]    wrPtr;
    logic [ptrWidth-1:0]    rdPtr;
    logic [cntWidth-1:0]    count;
    logic                   full;
    logic                   doPush;
    logic                   doPop;

    assign full     = (count == cntWidth'(`FIFO_DEPTH));
    assign notEmpty = (count != '0);

    // full fifo loses the sample
    assign doPush = push && !full;
    // pop of an empty fifo is a no-op
    assign doPop  = pop && notEmpty;

    // oldest entry always on the output
    assign head = mem[rdPtr];

    // storage array
    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (clear) begin
            // flush, held every edge while clear is high
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == lastIdx) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == lastIdx) ? '0 : rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* common/sysregPkg.sv */
// shared types of the system register block
// adc sample word and its field layout
`include "sysreg_settings.svh"

package sysregPkg;

    // layout of one converter sample
    // {spare, channel, result}
    typedef struct packed {
        logic                                   spare;
        logic [`SAMPLE_WIDTH-`ADC_WIDTH-2:0]    channel;
        logic [`ADC_WIDTH-1:0]                  result;
    } adcFieldsT;

    // fifo stores the raw word
    // register bank decodes the fields
    typedef union packed {
        logic [`SAMPLE_WIDTH-1:0]   raw;
        adcFieldsT                  fields;
    } adcSampleT;

endpackage

/* common/sysreg_settings.svh */
// widths, counts and depths of the system register block
// bus address map and reserved read pattern
`ifndef SYSREG_SETTINGS_SVH
`define SYSREG_SETTINGS_SVH

// ====================
// sizes
// ====================
`define NUM_MOTORS        4
`define FIFO_DEPTH        16
`define BUS_WIDTH         32
`define ADDR_WIDTH        5

// speed word, valid flag sits just above the payload
`define SPEED_WIDTH       31
// sensor word is {voltValid, ampeValid, voltage, current}
`define SENSOR_WIDTH      34
`define SAMPLE_WIDTH      16
`define ADC_WIDTH         12

// ====================
// address map
// ====================
`define REG_PWM_DUTY      0
`define REG_MOTOR_DIR     1
`define REG_FB_DIR        2
`define REG_MOTOR_CTRL    3
`define REG_FIFO_STATUS   4

// per motor block: encoder, speed, voltage, current, spare word
`define MOTOR_REG_BASE    7
`define MOTOR_REG_STRIDE  5

// control register bit that flushes all sample fifos
`define CLEAR_ALL_BIT     31
`define RESERVED_WORD     32'hDEAD_BEEF

`endif
